/* compile.f */
+incdir+include
+incdir+bench
src/mips_pkg.sv
src/exec_decode.sv
src/exec_alu.sv
src/muldiv_unit.sv
src/exec_stage.sv
bench/exec_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exec_tb
SEED      ?= 34
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS = src/mips_pkg.sv src/exec_decode.sv src/exec_alu.sv \
           src/muldiv_unit.sv src/exec_stage.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

run: build
	./$(BUILD_DIR)/$(SIM_BIN)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+include $(RTL_SRCS) --top-module exec_stage

clean:
	rm -rf $(BUILD_DIR)

/* bench/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// expected output beat, care flags select the fields that are defined for the op
typedef struct packed {
    word_t     result;
    reg_addr_t dest;
    logic      write;
    logic      branch;
    logic      taken;
    logic      is_mem;
    logic      care_result;
    logic      care_dest;
} beat_t;

word_t model_hi = '0;
word_t model_lo = '0;

// HI/LO effect of mult, div and the moves to HI/LO, in program order
function automatic void update_hilo(input logic [5:0] fn, input word_t op1, input word_t op2);
    longint      sq;
    longint      sr;
    logic [63:0] p;
    case (fn)
        FN_MTHI: model_hi = op1;
        FN_MTLO: model_lo = op1;
        FN_MULT: begin
            p = 64'(longint'($signed(op1)) * longint'($signed(op2)));
            model_hi = p[63:32];
            model_lo = p[31:0];
        end
        FN_MULTU: begin
            p = {32'h0, op1} * {32'h0, op2};
            model_hi = p[63:32];
            model_lo = p[31:0];
        end
        FN_DIV, FN_DIVU: begin
            if (op2 == '0) begin
                model_lo = '1;  // x/0 rule
                model_hi = op1;
            end else if (fn == FN_DIV) begin
                sq = longint'($signed(op1)) / longint'($signed(op2));
                sr = longint'($signed(op1)) % longint'($signed(op2));
                model_lo = sq[31:0];
                model_hi = sr[31:0];
            end else begin
                model_lo = op1 / op2;
                model_hi = op1 % op2;
            end
        end
        default: ;
    endcase
endfunction

function automatic beat_t predict_beat(input word_t instr, input word_t op1,
                                       input word_t op2, input word_t pc);
    beat_t      e;
    logic [5:0] opc;
    logic [5:0] fn;
    logic [4:0] rt;
    logic [4:0] sa;
    word_t      simm;
    word_t      zimm;
    opc  = instr[31:26];
    fn   = instr[5:0];
    rt   = instr[20:16];
    simm = {{16{instr[15]}}, instr[15:0]};
    zimm = {16'h0, instr[15:0]};
    e    = '0;
    e.care_result = 1'b1;
    e.care_dest   = 1'b1;
    if (opc == OP_SPECIAL) begin
        sa      = fn[2] ? op1[4:0] : instr[10:6];  // variable forms take rs
        e.write = 1'b1;
        e.dest  = instr[15:11];
        case (fn)
            FN_SLL, FN_SLLV: e.result = op2 << sa;
            FN_SRL, FN_SRLV: e.result = op2 >> sa;
            FN_SRA, FN_SRAV: e.result = (op2 >> sa) | (op2[31] ? ~(32'hffff_ffff >> sa) : 32'h0);
            FN_ADD, FN_ADDU: e.result = op1 + op2;
            FN_SUB, FN_SUBU: e.result = op1 - op2;
            FN_AND:          e.result = op1 & op2;
            FN_OR:           e.result = op1 | op2;
            FN_XOR:          e.result = op1 ^ op2;
            FN_NOR:          e.result = ~(op1 | op2);
            FN_SLT:          e.result = word_t'((op1 ^ 32'h8000_0000) < (op2 ^ 32'h8000_0000));
            FN_SLTU:         e.result = word_t'(op1 < op2);
            FN_MFHI:         e.result = model_hi;
            FN_MFLO:         e.result = model_lo;
            default: begin
                e.write       = 1'b0;  // mult/div and mthi/mtlo
                e.care_result = 1'b0;
                e.care_dest   = 1'b0;
                update_hilo(fn, op1, op2);
            end
        endcase
    end else if ((opc == OP_REGIMM) || ((opc >= OP_BEQ) && (opc <= OP_BGTZ))) begin
        e.branch    = 1'b1;
        e.result    = pc + 32'd8;
        e.care_dest = 1'b0;
        case (opc)
            OP_BEQ:  e.taken = (op1 == op2);
            OP_BNE:  e.taken = (op1 != op2);
            OP_BLEZ: e.taken = ($signed(op1) <= 0);
            OP_BGTZ: e.taken = ($signed(op1) > 0);
            default: begin
                if ((rt == RT_BGEZ) || (rt == RT_BGEZAL)) begin
                    e.taken = ($signed(op1) >= 0);
                end else begin
                    e.taken = ($signed(op1) < 0);
                end
                if ((rt == RT_BLTZAL) || (rt == RT_BGEZAL)) begin
                    e.care_dest = 1'b1;
                    e.dest      = 5'd31;
                    e.write     = e.taken;
                end
            end
        endcase
    end else if (opc[5]) begin
        e.is_mem    = 1'b1;  // loads and stores only give the address
        e.result    = op1 + simm;
        e.care_dest = 1'b0;
    end else begin
        e.write = 1'b1;
        e.dest  = rt;
        case (opc)
            OP_SLTI:  e.result = word_t'((op1 ^ 32'h8000_0000) < (simm ^ 32'h8000_0000));
            OP_SLTIU: e.result = word_t'(op1 < simm);
            OP_ANDI:  e.result = op1 & zimm;
            OP_ORI:   e.result = op1 | zimm;
            OP_XORI:  e.result = op1 ^ zimm;
            OP_LUI:   e.result = {instr[15:0], 16'h0};
            default:  e.result = op1 + simm;  // addi, addiu
        endcase
    end
    return e;
endfunction

`endif

/* bench/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb
    import mips_pkg::*;
#(
    parameter int SEED = 34
);
    localparam int     CLK_PERIOD   = 10;
    localparam int     RESET_CYCLES = 16;
    localparam int     N_GROUPS     = 400;
    localparam int     PLANNED      = 3 * N_GROUPS + 4;  // a group is at most three instrs
    localparam longint WATCHDOG_NS  = longint'(RESET_CYCLES + 40 * PLANNED) * CLK_PERIOD;
    localparam int     DRAIN_CYCLES = 100;

    localparam logic [5:0] R_FUNCTS [16] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV,
        FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU};
    localparam logic [5:0] I_OPS [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
        OP_ORI, OP_XORI, OP_LUI};
    localparam logic [5:0] MEM_OPS [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB,
        OP_SH, OP_SW};
    localparam logic [5:0] BR_OPS [4] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};
    localparam logic [4:0] RT_CODES [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
    localparam logic [5:0] MD_FUNCTS [4] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    word_t     in_instr;
    word_t     in_op1;
    word_t     in_op2;
    word_t     in_pc;
    logic      out_valid;
    logic      out_ready;
    word_t     out_result;
    reg_addr_t out_dest;
    logic      out_write;
    logic      out_branch;
    logic      out_taken;
    logic      out_is_mem;

    `include "exec_model.svh"

    beat_t       exp_q [$];
    int          n_sent;
    int          n_accepted;
    int          n_checked;
    logic [31:0] rng;
    logic [31:0] ready_rng;
    logic        held;
    logic [40:0] held_payload;
    logic [40:0] payload;

    assign payload = {out_result, out_dest, out_write, out_branch, out_taken, out_is_mem};

    exec_stage #(
        .DIV_STEPS (32)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .in_op1     (in_op1),
        .in_op2     (in_op2),
        .in_pc      (in_pc),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_dest   (out_dest),
        .out_write  (out_write),
        .out_branch (out_branch),
        .out_taken  (out_taken),
        .out_is_mem (out_is_mem)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] draw_stim();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // corner values show up far more often than in a flat draw
    function automatic word_t pick_operand();
        logic [31:0] r;
        r = draw_stim();
        case (r[1:0])
            2'd0:    return {{28{r[5]}}, r[5:2]};
            2'd1: begin
                case (r[5:4])
                    2'd0:    return 32'h0;
                    2'd1:    return 32'h8000_0000;
                    2'd2:    return 32'hffff_ffff;
                    default: return 32'h7fff_ffff;
                endcase
            end
            default: return draw_stim();
        endcase
    endfunction

    function automatic word_t move_instr(input logic [5:0] fn, input logic [4:0] rd);
        return {OP_SPECIAL, 10'h0, rd, 5'h0, fn};
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_field(input string name, input word_t got, input word_t exp);
        fail_now($sformatf("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_beat(input beat_t e);
        if (e.care_result) begin
            assert (out_result == e.result) else report_field("out_result", out_result, e.result);
        end
        if (e.care_dest) begin
            assert (out_dest == e.dest) else report_field("out_dest", 32'(out_dest), 32'(e.dest));
        end
        assert (out_write == e.write) else report_field("out_write", 32'(out_write), 32'(e.write));
        assert (out_branch == e.branch)
            else report_field("out_branch", 32'(out_branch), 32'(e.branch));
        assert (out_taken == e.taken) else report_field("out_taken", 32'(out_taken), 32'(e.taken));
        assert (out_is_mem == e.is_mem)
            else report_field("out_is_mem", 32'(out_is_mem), 32'(e.is_mem));
    endtask

    // called just after a rising edge, returns just after the accepting edge
    task automatic send_instr(input word_t instr, input word_t op1, input word_t op2);
        in_instr = instr;
        in_op1   = op1;
        in_op2   = op2;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);  // in_ready is settled by mid cycle
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_pc    = in_pc + 32'd4;
        n_sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // back-pressure with occasional longer low phases
    initial begin
        int low_left;
        low_left  = 0;
        out_ready = 1'b0;
        ready_rng = xorshift32(32'(SEED) ^ 32'h9e37_79b9);
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            if (low_left != 0) begin
                low_left--;
                out_ready = 1'b0;
            end else begin
                ready_rng = xorshift32(ready_rng);
                if (ready_rng[3:0] == 4'd0) low_left = int'(ready_rng[6:4]);
                out_ready = (ready_rng[9:8] != 2'd0);
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (held) begin
                assert (out_valid) else fail_now("out_valid dropped before the beat was taken");
                assert (payload == held_payload)
                    else fail_now($sformatf("mismatch at %0d ns: payload changed while held", $time));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    fail_now("an output beat came out with no accepted input behind it");
                end else begin
                    check_beat(exp_q.pop_front());
                    n_checked++;
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(predict_beat(in_instr, in_op1, in_op2, in_pc));
                n_accepted++;
            end
            held         = out_valid && !out_ready;
            held_payload = payload;
        end else begin
            held = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("timeout: the run hung before all output beats were checked");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        word_t       a;
        word_t       b;
        logic [2:0]  k;
        rng        = 32'(SEED);
        n_sent     = 0;
        n_accepted = 0;
        n_checked  = 0;
        held       = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        in_op1     = '0;
        in_op2     = '0;
        in_pc      = 32'h0040_0000;
        rst_n      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && in_ready)
            else fail_now("stage not idle after reset: out_valid high or in_ready low");
        @(posedge clk);
        #1;
        send_instr(move_instr(FN_MFHI, 5'd2), 32'h1234_5678, 32'h0);  // HI is still zero
        // negative dividend over a zero divisor
        send_instr({OP_SPECIAL, 20'h0, FN_DIV}, 32'hffff_fff9, 32'h0);
        send_instr(move_instr(FN_MFHI, 5'd3), 32'h0, 32'h0);
        send_instr(move_instr(FN_MFLO, 5'd4), 32'h0, 32'h0);
        for (int g = 0; g < N_GROUPS; g++) begin
            r = draw_stim();
            w = draw_stim();
            k = r[6:4];
            a = pick_operand();
            b = (r[31:30] == 2'd0) ? a : pick_operand();  // equal pairs give zeros and beq hits
            if (r[13:12] == 2'd0) idle_cycles(int'(r[15:14]) + 1);
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
                    send_instr({OP_SPECIAL, w[25:6], R_FUNCTS[r[7:4]]}, a, b);
                4'd5, 4'd6, 4'd7:
                    send_instr({I_OPS[k], w[25:0]}, a, b);
                4'd8, 4'd9, 4'd10: begin
                    if (!k[2]) send_instr({BR_OPS[k[1:0]], w[25:0]}, a, b);
                    else send_instr({OP_REGIMM, w[25:21], RT_CODES[k[1:0]], w[15:0]}, a, b);
                end
                4'd11, 4'd12:
                    send_instr({MEM_OPS[k], w[25:0]}, a, b);
                4'd13, 4'd14: begin
                    send_instr({OP_SPECIAL, w[25:16], 10'h0, MD_FUNCTS[r[5:4]]}, a, b);
                    send_instr(move_instr(r[7] ? FN_MFLO : FN_MFHI, w[4:0]), b, a);
                    send_instr(move_instr(r[7] ? FN_MFHI : FN_MFLO, w[9:5]), a, b);
                end
                default: begin
                    send_instr(move_instr(r[7] ? FN_MTHI : FN_MTLO, 5'd0), a, b);
                    send_instr(move_instr(FN_MFHI, w[4:0]), b, a);
                    send_instr(move_instr(FN_MFLO, w[9:5]), b, a);
                end
            endcase
        end
        for (int i = 0; (i < DRAIN_CYCLES) && (exp_q.size() != 0); i++) @(posedge clk);
        repeat (4) @(posedge clk);
        if ((n_checked == n_accepted) && (n_accepted == n_sent) && !out_valid) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_now($sformatf("beat count off: %0d sent, %0d accepted, %0d checked",
                               n_sent, n_accepted, n_checked));
        end
    end

endmodule

/* src/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
    import mips_pkg::*;
#(
    parameter int DIV_STEPS = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_instr,
    input  word_t     in_op1,
    input  word_t     in_op2,
    input  word_t     in_pc,
    output logic      out_valid,
    input  logic      out_ready,
    output word_t     out_result,
    output reg_addr_t out_dest,
    output logic      out_write,
    output logic      out_branch,
    output logic      out_taken,
    output logic      out_is_mem
);
    op_class_e  op_class;
    alu_fn_e    alu_fn;
    muldiv_op_e md_op;
    logic       use_imm;
    word_t      imm;
    shamt_t     shamt;
    logic       shift_var;
    reg_addr_t  dest;
    logic       write;
    logic       link;
    logic       hilo_sel_hi;
    word_t      alu_result;
    logic       taken;
    logic       busy;
    word_t      hi;
    word_t      lo;
    logic       accept;
    word_t      beat_result;
    logic       beat_write;

    exec_decode decode_i (
        .instr       (in_instr),
        .op_class    (op_class),
        .alu_fn      (alu_fn),
        .md_op       (md_op),
        .use_imm     (use_imm),
        .imm         (imm),
        .shamt       (shamt),
        .shift_var   (shift_var),
        .dest        (dest),
        .write       (write),
        .link        (link),
        .hilo_sel_hi (hilo_sel_hi)
    );

    exec_alu alu_i (
        .op_class  (op_class),
        .alu_fn    (alu_fn),
        .op1       (in_op1),
        .op2       (in_op2),
        .use_imm   (use_imm),
        .imm       (imm),
        .shamt     (shamt),
        .shift_var (shift_var),
        .instr_op  (in_instr[31:26]),
        .rt_code   (in_instr[20:16]),
        .pc        (in_pc),
        .result    (alu_result),
        .taken     (taken)
    );

    muldiv_unit #(
        .DIV_STEPS (DIV_STEPS)
    ) muldiv_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (accept && (op_class == muldiv_start)),
        .op       (md_op),
        .a        (in_op1),
        .b        (in_op2),
        .write_hi (accept && (op_class == move_to_hilo) && hilo_sel_hi),
        .write_lo (accept && (op_class == move_to_hilo) && !hilo_sel_hi),
        .wdata    (in_op1),  // mthi/mtlo take rs
        .busy     (busy),
        .hi       (hi),
        .lo       (lo)
    );

    // everything waits on a running mult/div so results stay in order
    assign in_ready = (!out_valid || out_ready) && !busy;
    assign accept   = in_valid && in_ready;

    always_comb begin
        case (op_class)
            alu, branch, mem_addr: beat_result = alu_result;
            move_from_hilo:        beat_result = hilo_sel_hi ? hi : lo;
            default:               beat_result = '0;
        endcase
    end

    assign beat_write = link ? taken : write;  // link only when taken

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_result <= beat_result;
            out_dest   <= dest;
            out_write  <= beat_write;
            out_branch <= (op_class == branch);
            out_taken  <= taken;
            out_is_mem <= (op_class == mem_addr);
        end
    end

endmodule

/* src/muldiv_unit.sv */
`timescale 1ns/1ps

module muldiv_unit
    import mips_pkg::*;
#(
    parameter int DIV_STEPS = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  muldiv_op_e op,
    input  word_t      a,
    input  word_t      b,
    input  logic       write_hi,
    input  logic       write_lo,
    input  word_t      wdata,
    output logic       busy,
    output word_t      hi,
    output word_t      lo
);
    localparam int CNT_W = $clog2(DIV_STEPS + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_mult,
        st_div
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    logic [63:0]      prod;
    logic [63:0]      prod_s;
    logic [63:0]      prod_u;
    logic             div_signed;
    logic             a_neg;
    logic             b_neg;
    word_t            a_mag;
    word_t            b_mag;
    word_t            rem;
    word_t            quo;
    word_t            dvs;
    logic             neg_q;
    logic             neg_r;
    logic [32:0]      shifted;
    logic [32:0]      trial;
    logic             div_done;

    assign prod_s = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    assign prod_u = {32'h0, a} * {32'h0, b};

    assign div_signed = (op == div);
    assign a_neg      = div_signed && a[31];
    assign b_neg      = div_signed && b[31];
    assign a_mag      = a_neg ? -a : a;
    assign b_mag      = b_neg ? -b : b;

    // one restoring step, dividend bits come out of the top of quo
    assign shifted  = {rem, quo[31]};
    assign trial    = shifted - {1'b0, dvs};
    assign div_done = (cnt == CNT_W'(DIV_STEPS));

    assign busy = (state != st_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= ((op == mult) || (op == multu)) ? st_mult : st_div;
                        cnt   <= '0;
                    end
                    if (write_hi) hi <= wdata;  // mthi
                    if (write_lo) lo <= wdata;  // mtlo
                end
                st_mult: begin
                    hi    <= prod[63:32];
                    lo    <= prod[31:0];
                    state <= st_idle;
                end
                st_div: begin
                    if (div_done) begin
                        hi    <= neg_r ? -rem : rem;  // remainder follows dividend sign
                        lo    <= neg_q ? -quo : quo;
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            prod  <= (op == mult) ? prod_s : prod_u;
            rem   <= '0;
            quo   <= a_mag;
            dvs   <= b_mag;
            neg_q <= (a_neg ^ b_neg) && (b != '0);  // x/0 keeps all-ones quotient
            neg_r <= a_neg;
        end else if ((state == st_div) && !div_done) begin
            rem <= trial[32] ? shifted[31:0] : trial[31:0];  // restore when negative
            quo <= {quo[30:0], ~trial[32]};
        end
    end

endmodule

/* src/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu
    import mips_pkg::*;
(
    input  op_class_e  op_class,
    input  alu_fn_e    alu_fn,
    input  word_t      op1,         // rs
    input  word_t      op2,         // rt
    input  logic       use_imm,
    input  word_t      imm,
    input  shamt_t     shamt,
    input  logic       shift_var,
    input  logic [5:0] instr_op,
    input  reg_addr_t  rt_code,
    input  word_t      pc,
    output word_t      result,
    output logic       taken
);
    word_t  b;
    shamt_t sh;
    word_t  alu_val;

    assign b  = use_imm ? imm : op2;
    assign sh = shift_var ? op1[4:0] : shamt;  // only five bits of rs count

    always_comb begin
        case (alu_fn)
            add:     alu_val = op1 + b;  // overflow wraps, no trap
            sub:     alu_val = op1 - b;
            and_op:  alu_val = op1 & b;
            or_op:   alu_val = op1 | b;
            xor_op:  alu_val = op1 ^ b;
            nor_op:  alu_val = ~(op1 | b);
            slt:     alu_val = {31'h0, $signed(op1) < $signed(b)};
            sltu:    alu_val = {31'h0, op1 < b};
            sll:     alu_val = b << sh;
            srl:     alu_val = b >> sh;
            sra:     alu_val = word_t'($signed(b) >>> sh);
            lui:     alu_val = {b[15:0], 16'h0};
            default: alu_val = '0;
        endcase
    end

    // branch outcome, signed compares against rt or zero
    always_comb begin
        taken = 1'b0;
        if (op_class == branch) begin
            case (instr_op)
                OP_BEQ:  taken = (op1 == op2);
                OP_BNE:  taken = (op1 != op2);
                OP_BLEZ: taken = op1[31] || (op1 == '0);
                OP_BGTZ: taken = !op1[31] && (op1 != '0);
                OP_REGIMM: begin
                    if ((rt_code == RT_BGEZ) || (rt_code == RT_BGEZAL)) begin
                        taken = !op1[31];
                    end else begin
                        taken = op1[31];  // bltz, bltzal
                    end
                end
                default: taken = 1'b0;
            endcase
        end
    end

    // link value past the delay slot
    assign result = (op_class == branch) ? pc + 32'd8 : alu_val;

endmodule

/* src/exec_decode.sv */
`timescale 1ns/1ps

module exec_decode
    import mips_pkg::*;
(
    input  word_t      instr,
    output op_class_e  op_class,
    output alu_fn_e    alu_fn,
    output muldiv_op_e md_op,
    output logic       use_imm,
    output word_t      imm,
    output shamt_t     shamt,
    output logic       shift_var,
    output reg_addr_t  dest,
    output logic       write,
    output logic       link,
    output logic       hilo_sel_hi
);
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       zext;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];

    // logical immediates are zero extended, everything else sign extended
    assign zext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign imm  = zext ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    assign use_imm     = opcode[5] || opcode[3];  // imm alu ops and loads/stores
    assign shift_var   = (opcode == OP_SPECIAL) && (funct[5:3] == 3'b000) && funct[2];
    assign md_op       = muldiv_op_e'(funct[1:0]);
    assign hilo_sel_hi = (funct == FN_MFHI) || (funct == FN_MTHI);
    assign link        = (opcode == OP_REGIMM) && ((rt == RT_BLTZAL) || (rt == RT_BGEZAL));

    always_comb begin
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                    FN_XOR, FN_NOR, FN_SLT, FN_SLTU:     op_class = alu;
                    FN_MFHI, FN_MFLO:                    op_class = move_from_hilo;
                    FN_MTHI, FN_MTLO:                    op_class = move_to_hilo;
                    FN_MULT, FN_MULTU, FN_DIV, FN_DIVU:  op_class = muldiv_start;
                    default:                             op_class = nop;
                endcase
            end
            OP_REGIMM: begin
                op_class = (rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL}) ? branch : nop;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:            op_class = branch;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:            op_class = alu;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW:                         op_class = mem_addr;
            default:                                     op_class = nop;
        endcase
    end

    always_comb begin
        alu_fn = add;  // also the address add for loads/stores
        if (opcode == OP_SPECIAL) begin
            case (funct)
                FN_SUB, FN_SUBU:  alu_fn = sub;
                FN_AND:           alu_fn = and_op;
                FN_OR:            alu_fn = or_op;
                FN_XOR:           alu_fn = xor_op;
                FN_NOR:           alu_fn = nor_op;
                FN_SLT:           alu_fn = slt;
                FN_SLTU:          alu_fn = sltu;
                FN_SLL, FN_SLLV:  alu_fn = sll;
                FN_SRL, FN_SRLV:  alu_fn = srl;
                FN_SRA, FN_SRAV:  alu_fn = sra;
                default:          alu_fn = add;
            endcase
        end else begin
            case (opcode)
                OP_SLTI:  alu_fn = slt;
                OP_SLTIU: alu_fn = sltu;
                OP_ANDI:  alu_fn = and_op;
                OP_ORI:   alu_fn = or_op;
                OP_XORI:  alu_fn = xor_op;
                OP_LUI:   alu_fn = lui;
                default:  alu_fn = add;
            endcase
        end
    end

    // for branches write means "writes if taken"
    assign write = (op_class == alu) || (op_class == move_from_hilo) || link;
    assign dest  = link ? LINK_REG :
                   !write ? '0 :
                   (opcode == OP_SPECIAL) ? rd : rt;

endmodule

/* src/mips_pkg.sv */
package mips_pkg;

    `include "mips_isa.svh"

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    localparam reg_addr_t LINK_REG = 5'd31;  // $ra for the linking branches

    typedef enum logic [2:0] {
        alu,
        branch,
        mem_addr,
        muldiv_start,
        move_from_hilo,
        move_to_hilo,
        nop
    } op_class_e;

    // order follows funct[1:0] of MULT..DIVU
    typedef enum logic [1:0] {
        mult,
        multu,
        div,
        divu
    } muldiv_op_e;

    typedef enum logic [3:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        nor_op,
        slt,
        sltu,
        sll,
        srl,
        sra,
        lui
    } alu_fn_e;

endpackage

/* include/mips_isa.svh */
`ifndef MIPS_ISA_SVH
`define MIPS_ISA_SVH

// primary opcodes, instr[31:26]
localparam logic [5:0] OP_SPECIAL = 6'd0;
localparam logic [5:0] OP_REGIMM  = 6'd1;
localparam logic [5:0] OP_BEQ     = 6'd4;
localparam logic [5:0] OP_BNE     = 6'd5;
localparam logic [5:0] OP_BLEZ    = 6'd6;
localparam logic [5:0] OP_BGTZ    = 6'd7;
localparam logic [5:0] OP_ADDI    = 6'd8;
localparam logic [5:0] OP_ADDIU   = 6'd9;
localparam logic [5:0] OP_SLTI    = 6'd10;
localparam logic [5:0] OP_SLTIU   = 6'd11;
localparam logic [5:0] OP_ANDI    = 6'd12;
localparam logic [5:0] OP_ORI     = 6'd13;
localparam logic [5:0] OP_XORI    = 6'd14;
localparam logic [5:0] OP_LUI     = 6'd15;
localparam logic [5:0] OP_LB      = 6'd32;
localparam logic [5:0] OP_LH      = 6'd33;
localparam logic [5:0] OP_LW      = 6'd35;
localparam logic [5:0] OP_LBU     = 6'd36;
localparam logic [5:0] OP_LHU     = 6'd37;
localparam logic [5:0] OP_SB      = 6'd40;
localparam logic [5:0] OP_SH      = 6'd41;
localparam logic [5:0] OP_SW      = 6'd43;

// SPECIAL funct codes, instr[5:0]
localparam logic [5:0] FN_SLL   = 6'd0;
localparam logic [5:0] FN_SRL   = 6'd2;
localparam logic [5:0] FN_SRA   = 6'd3;
localparam logic [5:0] FN_SLLV  = 6'd4;
localparam logic [5:0] FN_SRLV  = 6'd6;
localparam logic [5:0] FN_SRAV  = 6'd7;
localparam logic [5:0] FN_MFHI  = 6'd16;
localparam logic [5:0] FN_MTHI  = 6'd17;
localparam logic [5:0] FN_MFLO  = 6'd18;
localparam logic [5:0] FN_MTLO  = 6'd19;
localparam logic [5:0] FN_MULT  = 6'd24;
localparam logic [5:0] FN_MULTU = 6'd25;
localparam logic [5:0] FN_DIV   = 6'd26;
localparam logic [5:0] FN_DIVU  = 6'd27;
localparam logic [5:0] FN_ADD   = 6'd32;
localparam logic [5:0] FN_ADDU  = 6'd33;
localparam logic [5:0] FN_SUB   = 6'd34;
localparam logic [5:0] FN_SUBU  = 6'd35;
localparam logic [5:0] FN_AND   = 6'd36;
localparam logic [5:0] FN_OR    = 6'd37;
localparam logic [5:0] FN_XOR   = 6'd38;
localparam logic [5:0] FN_NOR   = 6'd39;
localparam logic [5:0] FN_SLT   = 6'd42;
localparam logic [5:0] FN_SLTU  = 6'd43;

// REGIMM rt codes, instr[20:16]
localparam logic [4:0] RT_BLTZ   = 5'd0;
localparam logic [4:0] RT_BGEZ   = 5'd1;
localparam logic [4:0] RT_BLTZAL = 5'd16;
localparam logic [4:0] RT_BGEZAL = 5'd17;

`endif
